//--- design/id_pkg.sv
`default_nettype none

package id_pkg;

	////////////////////////////////////////
	// ISA widths
	////////////////////////////////////////

	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// return address register of JAL, BGEZAL and BLTZAL
	localparam reg_addr_t LINK_REG = 5'd31;

	////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////

	// major opcode, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_REGIMM  = 6'b000001,
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_BLEZ    = 6'b000110,
		OP_BGTZ    = 6'b000111,
		OP_ADDI    = 6'b001000,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111
	} opcode_e;

	// SPECIAL function field, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000,
		FN_SRL  = 6'b000010,
		FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100,
		FN_SRLV = 6'b000110,
		FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// REGIMM branches, selected by the rt field
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'b00000,
		RI_BGEZ   = 5'b00001,
		RI_BLTZAL = 5'b10000,
		RI_BGEZAL = 5'b10001
	} regimm_e;

	////////////////////////////////////////
	// execute stage encodings
	////////////////////////////////////////

	typedef enum logic [7:0] {
		ALU_NOP    = 8'b00000000,
		ALU_AND    = 8'b00100100,
		ALU_OR     = 8'b00100101,
		ALU_XOR    = 8'b00100110,
		ALU_NOR    = 8'b00100111,
		ALU_SLL    = 8'b01111100,
		ALU_SRL    = 8'b00000010,
		ALU_SRA    = 8'b00000011,
		ALU_SLT    = 8'b00101010,
		ALU_SLTU   = 8'b00101011,
		ALU_ADD    = 8'b00100000,
		ALU_ADDU   = 8'b00100001,
		ALU_SUB    = 8'b00100010,
		ALU_SUBU   = 8'b00100011,
		ALU_ADDI   = 8'b01010101,
		ALU_ADDIU  = 8'b01010110,
		ALU_J      = 8'b01001111,
		ALU_JAL    = 8'b01010000,
		ALU_JR     = 8'b00001000,
		ALU_JALR   = 8'b00001001,
		ALU_BEQ    = 8'b01010001,
		ALU_BNE    = 8'b01010010,
		ALU_BGTZ   = 8'b01010100,
		ALU_BLEZ   = 8'b01010011,
		ALU_BGEZ   = 8'b01000001,
		ALU_BLTZ   = 8'b01000000,
		ALU_BGEZAL = 8'b01001011,
		ALU_BLTZAL = 8'b01001010
	} alu_op_e;

	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110
	} alu_sel_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_ALWAYS,
		BR_EQ,
		BR_NE,
		BR_GTZ,
		BR_LEZ,
		BR_GEZ,
		BR_LTZ
	} branch_cond_e;

	////////////////////////////////////////
	// stage bundles
	////////////////////////////////////////

	// one register file read port
	typedef struct packed {
		logic      en;
		reg_addr_t addr;
	} rf_read_t;

	// writeback seen in EX or MEM, used for bypassing
	typedef struct packed {
		logic      wr_en;
		reg_addr_t wr_addr;
		word_t     data;
	} wb_fwd_t;

	typedef struct packed {
		alu_op_e      alu_op;
		alu_sel_e     alu_sel;
		logic         wr_en;
		reg_addr_t    wr_addr;
		word_t        imm;
		branch_cond_e branch_cond;
		logic         link;
		// target comes from rs (JR, JALR)
		logic         reg_target;
	} decode_ctrl_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		word_t     op1;
		word_t     op2;
		reg_addr_t wr_addr;
		logic      wr_en;
		word_t     link_addr;
	} id_ex_t;

	typedef struct packed {
		logic  taken;
		word_t target;
	} branch_t;

endpackage

`default_nettype wire

//--- design/inst_decoder.sv
`default_nettype none

module inst_decoder (
	input  wire id_pkg::word_t   inst_i,
	output id_pkg::decode_ctrl_t ctrl_o,
	output id_pkg::rf_read_t     rd1_o,
	output id_pkg::rf_read_t     rd2_o
);

	logic [5:0]        opcode;
	id_pkg::reg_addr_t rs;
	id_pkg::reg_addr_t rt;
	id_pkg::reg_addr_t rd;
	logic [4:0]        shamt;
	logic [5:0]        funct;
	logic [15:0]       imm16;

	// R-type operation looked up from the function field
	id_pkg::alu_op_e   r_op;
	id_pkg::alu_sel_e  r_sel;
	logic              imm_shift;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign shamt  = inst_i[10:6];
	assign funct  = inst_i[5:0];
	assign imm16  = inst_i[15:0];

	assign imm_shift = (funct == id_pkg::FN_SLL) || (funct == id_pkg::FN_SRL) ||
		(funct == id_pkg::FN_SRA);

	always_comb begin
		case (funct)
			id_pkg::FN_SLL, id_pkg::FN_SLLV: r_op = id_pkg::ALU_SLL;
			id_pkg::FN_SRL, id_pkg::FN_SRLV: r_op = id_pkg::ALU_SRL;
			id_pkg::FN_SRA, id_pkg::FN_SRAV: r_op = id_pkg::ALU_SRA;
			id_pkg::FN_AND:                  r_op = id_pkg::ALU_AND;
			id_pkg::FN_OR:                   r_op = id_pkg::ALU_OR;
			id_pkg::FN_XOR:                  r_op = id_pkg::ALU_XOR;
			id_pkg::FN_NOR:                  r_op = id_pkg::ALU_NOR;
			id_pkg::FN_ADD:                  r_op = id_pkg::ALU_ADD;
			id_pkg::FN_ADDU:                 r_op = id_pkg::ALU_ADDU;
			id_pkg::FN_SUB:                  r_op = id_pkg::ALU_SUB;
			id_pkg::FN_SUBU:                 r_op = id_pkg::ALU_SUBU;
			id_pkg::FN_SLT:                  r_op = id_pkg::ALU_SLT;
			id_pkg::FN_SLTU:                 r_op = id_pkg::ALU_SLTU;
			id_pkg::FN_JR:                   r_op = id_pkg::ALU_JR;
			id_pkg::FN_JALR:                 r_op = id_pkg::ALU_JALR;
			default:                         r_op = id_pkg::ALU_NOP;
		endcase
		case (funct)
			id_pkg::FN_SLL, id_pkg::FN_SRL, id_pkg::FN_SRA,
			id_pkg::FN_SLLV, id_pkg::FN_SRLV, id_pkg::FN_SRAV: r_sel = id_pkg::SEL_SHIFT;
			id_pkg::FN_AND, id_pkg::FN_OR, id_pkg::FN_XOR,
			id_pkg::FN_NOR: r_sel = id_pkg::SEL_LOGIC;
			id_pkg::FN_ADD, id_pkg::FN_ADDU, id_pkg::FN_SUB, id_pkg::FN_SUBU,
			id_pkg::FN_SLT, id_pkg::FN_SLTU: r_sel = id_pkg::SEL_ARITH;
			id_pkg::FN_JR, id_pkg::FN_JALR: r_sel = id_pkg::SEL_JUMP_BRANCH;
			default: r_sel = id_pkg::SEL_NOP;
		endcase
	end

	////////////////////////////////////////
	// main decode
	////////////////////////////////////////

	always_comb begin
		// anything not matched below stays a NOP without write
		ctrl_o             = '0;
		ctrl_o.alu_op      = id_pkg::ALU_NOP;
		ctrl_o.alu_sel     = id_pkg::SEL_NOP;
		ctrl_o.branch_cond = id_pkg::BR_NONE;
		rd1_o.en           = 1'b0;
		rd1_o.addr         = rs;
		rd2_o.en           = 1'b0;
		rd2_o.addr         = rt;

		case (opcode)
			id_pkg::OP_SPECIAL: begin
				if (imm_shift) begin
					// sll/srl/sra rd, rt, shamt; rs must be zero
					if (rs == '0) begin
						ctrl_o.alu_op  = r_op;
						ctrl_o.alu_sel = r_sel;
						ctrl_o.wr_en   = 1'b1;
						ctrl_o.wr_addr = rd;
						ctrl_o.imm     = id_pkg::word_t'(shamt);
						rd2_o.en       = 1'b1;
					end
				end else if (shamt == '0 && r_sel != id_pkg::SEL_NOP) begin
					ctrl_o.alu_op  = r_op;
					ctrl_o.alu_sel = r_sel;
					rd1_o.en       = 1'b1;
					if (r_sel == id_pkg::SEL_JUMP_BRANCH) begin
						ctrl_o.branch_cond = id_pkg::BR_ALWAYS;
						ctrl_o.reg_target  = 1'b1;
						// only JALR writes its return address, into rd
						if (funct == id_pkg::FN_JALR) begin
							ctrl_o.link    = 1'b1;
							ctrl_o.wr_en   = 1'b1;
							ctrl_o.wr_addr = rd;
						end
					end else begin
						ctrl_o.wr_en   = 1'b1;
						ctrl_o.wr_addr = rd;
						rd2_o.en       = 1'b1;
					end
				end
			end

			id_pkg::OP_ORI, id_pkg::OP_ANDI, id_pkg::OP_XORI, id_pkg::OP_LUI,
			id_pkg::OP_ADDI, id_pkg::OP_ADDIU, id_pkg::OP_SLTI, id_pkg::OP_SLTIU: begin
				ctrl_o.wr_en   = 1'b1;
				ctrl_o.wr_addr = rt;
				rd1_o.en       = 1'b1;
				// opcodes 0011xx are logic, 0010xx arithmetic
				ctrl_o.alu_sel = opcode[2] ? id_pkg::SEL_LOGIC : id_pkg::SEL_ARITH;
				if (opcode == id_pkg::OP_LUI) begin
					ctrl_o.imm = {imm16, 16'h0000};
				end else if (opcode[2]) begin
					ctrl_o.imm = {16'h0000, imm16};
				end else begin
					ctrl_o.imm = {{16{imm16[15]}}, imm16};
				end
				case (opcode)
					id_pkg::OP_ANDI:  ctrl_o.alu_op = id_pkg::ALU_AND;
					id_pkg::OP_XORI:  ctrl_o.alu_op = id_pkg::ALU_XOR;
					id_pkg::OP_ADDI:  ctrl_o.alu_op = id_pkg::ALU_ADDI;
					id_pkg::OP_ADDIU: ctrl_o.alu_op = id_pkg::ALU_ADDIU;
					id_pkg::OP_SLTI:  ctrl_o.alu_op = id_pkg::ALU_SLT;
					id_pkg::OP_SLTIU: ctrl_o.alu_op = id_pkg::ALU_SLTU;
					// ORI and LUI both or into rs
					default:          ctrl_o.alu_op = id_pkg::ALU_OR;
				endcase
			end

			id_pkg::OP_J, id_pkg::OP_JAL: begin
				ctrl_o.alu_sel     = id_pkg::SEL_JUMP_BRANCH;
				ctrl_o.branch_cond = id_pkg::BR_ALWAYS;
				ctrl_o.alu_op      = id_pkg::ALU_J;
				if (opcode == id_pkg::OP_JAL) begin
					ctrl_o.alu_op  = id_pkg::ALU_JAL;
					ctrl_o.link    = 1'b1;
					ctrl_o.wr_en   = 1'b1;
					ctrl_o.wr_addr = id_pkg::LINK_REG;
				end
			end

			id_pkg::OP_BEQ, id_pkg::OP_BNE: begin
				ctrl_o.alu_sel = id_pkg::SEL_JUMP_BRANCH;
				rd1_o.en       = 1'b1;
				rd2_o.en       = 1'b1;
				if (opcode == id_pkg::OP_BEQ) begin
					ctrl_o.alu_op      = id_pkg::ALU_BEQ;
					ctrl_o.branch_cond = id_pkg::BR_EQ;
				end else begin
					ctrl_o.alu_op      = id_pkg::ALU_BNE;
					ctrl_o.branch_cond = id_pkg::BR_NE;
				end
			end

			id_pkg::OP_BLEZ, id_pkg::OP_BGTZ: begin
				ctrl_o.alu_sel = id_pkg::SEL_JUMP_BRANCH;
				rd1_o.en       = 1'b1;
				if (opcode == id_pkg::OP_BLEZ) begin
					ctrl_o.alu_op      = id_pkg::ALU_BLEZ;
					ctrl_o.branch_cond = id_pkg::BR_LEZ;
				end else begin
					ctrl_o.alu_op      = id_pkg::ALU_BGTZ;
					ctrl_o.branch_cond = id_pkg::BR_GTZ;
				end
			end

			id_pkg::OP_REGIMM: begin
				if (rt == id_pkg::RI_BLTZ || rt == id_pkg::RI_BLTZAL) begin
					ctrl_o.alu_op      = rt[4] ? id_pkg::ALU_BLTZAL : id_pkg::ALU_BLTZ;
					ctrl_o.branch_cond = id_pkg::BR_LTZ;
				end else if (rt == id_pkg::RI_BGEZ || rt == id_pkg::RI_BGEZAL) begin
					ctrl_o.alu_op      = rt[4] ? id_pkg::ALU_BGEZAL : id_pkg::ALU_BGEZ;
					ctrl_o.branch_cond = id_pkg::BR_GEZ;
				end
				if (ctrl_o.branch_cond != id_pkg::BR_NONE) begin
					ctrl_o.alu_sel = id_pkg::SEL_JUMP_BRANCH;
					rd1_o.en       = 1'b1;
					// the "al" forms link whether taken or not
					ctrl_o.link    = rt[4];
					ctrl_o.wr_en   = rt[4];
					ctrl_o.wr_addr = rt[4] ? id_pkg::LINK_REG : '0;
				end
			end

			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/operand_forward.sv
`default_nettype none

module operand_forward (
	input  wire id_pkg::rf_read_t rd_i,
	input  wire id_pkg::word_t    rf_data_i,
	input  wire id_pkg::wb_fwd_t  ex_fwd_i,
	input  wire id_pkg::wb_fwd_t  mem_fwd_i,
	input  wire id_pkg::word_t    imm_i,
	output id_pkg::word_t         operand_o
);

	logic ex_hit;
	logic mem_hit;

	// a writeback still in flight matches the register we are reading
	assign ex_hit  = ex_fwd_i.wr_en && (ex_fwd_i.wr_addr == rd_i.addr);
	assign mem_hit = mem_fwd_i.wr_en && (mem_fwd_i.wr_addr == rd_i.addr);

	always_comb begin
		if (!rd_i.en) begin
			// unused port carries the decoded immediate
			operand_o = imm_i;
		end else if (ex_hit) begin
			// youngest result first
			operand_o = ex_fwd_i.data;
		end else if (mem_hit) begin
			operand_o = mem_fwd_i.data;
		end else begin
			operand_o = rf_data_i;
		end
	end

endmodule

`default_nettype wire

//--- design/branch_unit.sv
`default_nettype none

module branch_unit (
	input  wire id_pkg::decode_ctrl_t ctrl_i,
	input  wire id_pkg::word_t        pc_i,
	input  wire id_pkg::word_t        inst_i,
	input  wire id_pkg::word_t        op1_i,
	input  wire id_pkg::word_t        op2_i,
	output id_pkg::branch_t           branch_o,
	output id_pkg::word_t             link_o
);

	id_pkg::word_t pc_plus_4;
	id_pkg::word_t pc_plus_8;
	id_pkg::word_t offset;
	id_pkg::word_t region_target;
	logic          op1_zero;
	logic          op1_neg;
	logic          taken;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;

	// 16-bit word offset, sign-extended and scaled to bytes
	assign offset = {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	// J and JAL stay inside the 256 MB region of the delay slot
	assign region_target = {pc_plus_4[31:28], inst_i[25:0], 2'b00};

	assign op1_zero = (op1_i == '0);
	assign op1_neg  = op1_i[id_pkg::XLEN-1];

	////////////////////////////////////////
	// condition
	////////////////////////////////////////

	always_comb begin
		case (ctrl_i.branch_cond)
			id_pkg::BR_ALWAYS: taken = 1'b1;
			id_pkg::BR_EQ:     taken = (op1_i == op2_i);
			id_pkg::BR_NE:     taken = (op1_i != op2_i);
			id_pkg::BR_GTZ:    taken = !op1_neg && !op1_zero;
			id_pkg::BR_LEZ:    taken = op1_neg || op1_zero;
			id_pkg::BR_GEZ:    taken = !op1_neg;
			id_pkg::BR_LTZ:    taken = op1_neg;
			default:           taken = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// target and link
	////////////////////////////////////////

	always_comb begin
		branch_o.taken = taken;
		if (!taken) begin
			branch_o.target = '0;
		end else if (ctrl_i.reg_target) begin
			branch_o.target = op1_i;
		end else if (ctrl_i.branch_cond == id_pkg::BR_ALWAYS) begin
			branch_o.target = region_target;
		end else begin
			branch_o.target = pc_plus_4 + offset;
		end
	end

	// return address skips the delay slot
	assign link_o = ctrl_i.link ? pc_plus_8 : '0;

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none

module decode_stage (
	input  wire                 clk_i,
	input  wire                 arst_n_i,

	// instruction from fetch
	input  wire id_pkg::word_t  pc_i,
	input  wire id_pkg::word_t  inst_i,

	// register file
	input  wire id_pkg::word_t  rf_data1_i,
	input  wire id_pkg::word_t  rf_data2_i,
	output id_pkg::rf_read_t    rf_rd1_o,
	output id_pkg::rf_read_t    rf_rd2_o,

	// bypass from later stages
	input  wire id_pkg::wb_fwd_t ex_fwd_i,
	input  wire id_pkg::wb_fwd_t mem_fwd_i,

	// to execute and fetch
	output id_pkg::id_ex_t      id_ex_o,
	output id_pkg::branch_t     branch_o
);

	id_pkg::decode_ctrl_t ctrl;
	id_pkg::word_t        op1;
	id_pkg::word_t        op2;
	id_pkg::word_t        link_word;
	id_pkg::branch_t      branch_d;
	id_pkg::id_ex_t       id_ex_d;

	inst_decoder u_decoder (
		.inst_i (inst_i),
		.ctrl_o (ctrl),
		.rd1_o  (rf_rd1_o),
		.rd2_o  (rf_rd2_o)
	);

	operand_forward u_fwd_op1 (
		.rd_i      (rf_rd1_o),
		.rf_data_i (rf_data1_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.imm_i     (ctrl.imm),
		.operand_o (op1)
	);

	operand_forward u_fwd_op2 (
		.rd_i      (rf_rd2_o),
		.rf_data_i (rf_data2_i),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.imm_i     (ctrl.imm),
		.operand_o (op2)
	);

	// jr/jalr targets see the bypassed rs value
	branch_unit u_branch (
		.ctrl_i   (ctrl),
		.pc_i     (pc_i),
		.inst_i   (inst_i),
		.op1_i    (op1),
		.op2_i    (op2),
		.branch_o (branch_d),
		.link_o   (link_word)
	);

	////////////////////////////////////////
	// ID/EX register
	////////////////////////////////////////

	always_comb begin
		id_ex_d.alu_op    = ctrl.alu_op;
		id_ex_d.alu_sel   = ctrl.alu_sel;
		id_ex_d.op1       = op1;
		id_ex_d.op2       = op2;
		id_ex_d.wr_addr   = ctrl.wr_addr;
		id_ex_d.wr_en     = ctrl.wr_en;
		id_ex_d.link_addr = link_word;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			// NOP, no write, not taken
			id_ex_o  <= '0;
			branch_o <= '0;
		end else begin
			id_ex_o  <= id_ex_d;
			branch_o <= branch_d;
		end
	end

endmodule

`default_nettype wire

//--- verification/decode_stage_assertions.sv
`default_nettype none

module decode_stage_assertions (
	input wire                       clk_i,
	input wire                       arst_n_i,
	input wire id_pkg::word_t        inst_i,
	input wire id_pkg::decode_ctrl_t ctrl_i,
	input wire id_pkg::id_ex_t       id_ex_i,
	input wire id_pkg::branch_t      branch_i
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned failures = 0;

	// a redirect only comes from a jump or a branch
	taken_is_jump_branch: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		branch_i.taken |-> id_ex_i.alu_sel == id_pkg::SEL_JUMP_BRANCH
	) else begin
		failures++;
		$error("taken redirect without the jump/branch result class");
	end

	// registers sit at a NOP while reset is held
	nop_during_reset: assert property (
		@(negedge clk_i)
		!arst_n_i |->
			!id_ex_i.wr_en && id_ex_i.alu_op == id_pkg::ALU_NOP && !branch_i.taken
	) else begin
		failures++;
		$error("ID/EX register is not a NOP during reset");
	end

	// return address goes to r31 or, for jalr, to rd
	link_destination: assert property (
		@(posedge clk_i) disable iff (!arst_n_i)
		ctrl_i.link && ctrl_i.wr_en |->
			ctrl_i.wr_addr == id_pkg::LINK_REG || ctrl_i.wr_addr == inst_i[15:11]
	) else begin
		failures++;
		$error("link write to a register other than r31 or rd");
	end

endmodule

`default_nettype wire

//--- verification/decode_stage_tb.sv
`default_nettype none

module decode_stage_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// one line of the vector file with every column widened to a word
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		logic [31:0] rf1;
		logic [31:0] rf2;
		logic [31:0] ex_en;
		logic [31:0] ex_addr;
		logic [31:0] ex_data;
		logic [31:0] mem_en;
		logic [31:0] mem_addr;
		logic [31:0] mem_data;
		logic [31:0] rd1_en;
		logic [31:0] rd1_addr;
		logic [31:0] rd2_en;
		logic [31:0] rd2_addr;
		logic [31:0] alu_op;
		logic [31:0] alu_sel;
		logic [31:0] op1;
		logic [31:0] op2;
		logic [31:0] wr_addr;
		logic [31:0] wr_en;
		logic [31:0] link;
		logic [31:0] taken;
		logic [31:0] target;
	} vector_t;

	logic             clk_i;
	logic             arst_n_i;
	id_pkg::word_t    pc_i;
	id_pkg::word_t    inst_i;
	id_pkg::word_t    rf_data1_i;
	id_pkg::word_t    rf_data2_i;
	id_pkg::wb_fwd_t  ex_fwd_i;
	id_pkg::wb_fwd_t  mem_fwd_i;
	id_pkg::rf_read_t rf_rd1_o;
	id_pkg::rf_read_t rf_rd2_o;
	id_pkg::id_ex_t   id_ex_o;
	id_pkg::branch_t  branch_o;

	vector_t vectors[$];
	string   load_error = "";
	int      current = 0;
	int      cycles = 0;
	int      cycle_limit = 0;

	decode_stage i_dut (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.pc_i       (pc_i),
		.inst_i     (inst_i),
		.rf_data1_i (rf_data1_i),
		.rf_data2_i (rf_data2_i),
		.rf_rd1_o   (rf_rd1_o),
		.rf_rd2_o   (rf_rd2_o),
		.ex_fwd_i   (ex_fwd_i),
		.mem_fwd_i  (mem_fwd_i),
		.id_ex_o    (id_ex_o),
		.branch_o   (branch_o)
	);

	bind decode_stage decode_stage_assertions u_assertions (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.inst_i   (inst_i),
		.ctrl_i   (ctrl),
		.id_ex_i  (id_ex_o),
		.branch_i (branch_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	// guard against a run that never reaches its end
	always @(posedge clk_i) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	// a failed property in the bound checker ends the run
	always @(i_dut.u_assertions.failures) begin
		if (i_dut.u_assertions.failures != 0) begin
			$display("An assertion on the decode stage failed");
			abort_run();
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Fail %s (vector %0d): got %h, expected %h",
				name, current, got, expected);
			abort_run();
		end
	endtask

	task automatic read_vectors();
		int      fd;
		int      count;
		string   line;
		vector_t v;
		fd = $fopen("verification/decode_tests.mem", "r");
		if (fd == 0) begin
			load_error = "the file verification/decode_tests.mem could not be opened";
			return;
		end
		while (load_error == "" && $fgets(line, fd) != 0) begin
			// blank lines and comment lines carry no vector
			if (line.len() > 1 && line.substr(0, 1) != "//") begin
				count = $sscanf(line,
					"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					v.pc, v.inst, v.rf1, v.rf2, v.ex_en, v.ex_addr, v.ex_data,
					v.mem_en, v.mem_addr, v.mem_data, v.rd1_en, v.rd1_addr,
					v.rd2_en, v.rd2_addr, v.alu_op, v.alu_sel, v.op1, v.op2,
					v.wr_addr, v.wr_en, v.link, v.taken, v.target);
				if (count == 23) begin
					vectors.push_back(v);
				end else begin
					load_error = $sformatf("a vector line has the wrong format: %s", line);
				end
			end
		end
		$fclose(fd);
		if (load_error == "" && vectors.size() == 0) begin
			load_error = "the vector file holds no vectors";
		end
	endtask

	task automatic drive_vector(input vector_t v);
		pc_i              = v.pc;
		inst_i            = v.inst;
		rf_data1_i        = v.rf1;
		rf_data2_i        = v.rf2;
		ex_fwd_i.wr_en    = v.ex_en[0];
		ex_fwd_i.wr_addr  = v.ex_addr[4:0];
		ex_fwd_i.data     = v.ex_data;
		mem_fwd_i.wr_en   = v.mem_en[0];
		mem_fwd_i.wr_addr = v.mem_addr[4:0];
		mem_fwd_i.data    = v.mem_data;
	endtask

	// inputs still hold v so the read ports are settled and the register holds v
	task automatic check_vector(input vector_t v);
		check_value("rf_rd1_o.en", rf_rd1_o.en, v.rd1_en);
		check_value("rf_rd1_o.addr", rf_rd1_o.addr, v.rd1_addr);
		check_value("rf_rd2_o.en", rf_rd2_o.en, v.rd2_en);
		check_value("rf_rd2_o.addr", rf_rd2_o.addr, v.rd2_addr);
		check_value("id_ex_o.alu_op", id_ex_o.alu_op, v.alu_op);
		check_value("id_ex_o.alu_sel", id_ex_o.alu_sel, v.alu_sel);
		check_value("id_ex_o.op1", id_ex_o.op1, v.op1);
		check_value("id_ex_o.op2", id_ex_o.op2, v.op2);
		check_value("id_ex_o.wr_addr", id_ex_o.wr_addr, v.wr_addr);
		check_value("id_ex_o.wr_en", id_ex_o.wr_en, v.wr_en);
		check_value("id_ex_o.link_addr", id_ex_o.link_addr, v.link);
		check_value("branch_o.taken", branch_o.taken, v.taken);
		check_value("branch_o.target", branch_o.target, v.target);
	endtask

	task automatic check_reset();
		check_value("id_ex_o.alu_op", id_ex_o.alu_op, id_pkg::ALU_NOP);
		check_value("id_ex_o.alu_sel", id_ex_o.alu_sel, id_pkg::SEL_NOP);
		check_value("id_ex_o.wr_en", id_ex_o.wr_en, 0);
		check_value("id_ex_o.wr_addr", id_ex_o.wr_addr, 0);
		check_value("id_ex_o.op1", id_ex_o.op1, 0);
		check_value("id_ex_o.op2", id_ex_o.op2, 0);
		check_value("branch_o.taken", branch_o.taken, 0);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		arst_n_i   = 1'b0;
		pc_i       = 32'h0000_0400;
		// a jump on the inputs that reset must hold off
		inst_i     = 32'h0810_0040;
		rf_data1_i = '0;
		rf_data2_i = '0;
		ex_fwd_i   = '0;
		mem_fwd_i  = '0;
		read_vectors();
		if (load_error != "") begin
			$display("Could not load the test vectors: %s", load_error);
			abort_run();
		end else begin
			cycle_limit = 2 * vectors.size() + 20;
			repeat (4) begin
				@(negedge clk_i);
				check_reset();
			end
			arst_n_i = 1'b1;
			foreach (vectors[i]) begin
				current = i;
				drive_vector(vectors[i]);
				@(negedge clk_i);
				check_vector(vectors[i]);
			end
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verification/decode_tests.mem
// stimulus: pc inst rf1 rf2 ex_en ex_addr ex_data mem_en mem_addr mem_data
// expect: rd1_en rd1_addr rd2_en rd2_addr alu_op alu_sel op1 op2 wr_addr wr_en link taken target
// immediates
400 34228001 100 200 1 2 9999 0 0 0 1 1 0 2 25 1 100 8001 2 1 0 0 0
404 3083f0f0 111 222 0 0 0 0 0 0 1 4 0 3 24 1 111 f0f0 3 1 0 0 0
408 38c5ffff 333 444 0 0 0 0 0 0 1 6 0 5 26 1 333 ffff 5 1 0 0 0
40c 3c071234 0 0 0 0 0 0 0 0 1 0 0 7 25 1 0 12340000 7 1 0 0 0
410 2128fffc 50 0 0 0 0 0 0 0 1 9 0 8 55 4 50 fffffffc 8 1 0 0 0
414 256a7fff 60 0 0 0 0 0 0 0 1 b 0 a 56 4 60 7fff a 1 0 0 0
418 29ac8000 70 0 0 0 0 0 0 0 1 d 0 c 2a 4 70 ffff8000 c 1 0 0 0
41c 2dee0010 80 0 0 0 0 0 0 0 1 f 0 e 2b 4 80 10 e 1 0 0 0
// register-register and shifts
420 00221820 10 20 0 0 0 0 0 0 1 1 1 2 20 4 10 20 3 1 0 0 0
424 00a62023 30 40 0 0 0 0 0 0 1 5 1 6 23 4 30 40 4 1 0 0 0
428 01093827 f0 f 0 0 0 0 0 0 1 8 1 9 27 1 f0 f 7 1 0 0 0
42c 016c502b 1 2 0 0 0 0 0 0 1 b 1 c 2b 4 1 2 a 1 0 0 0
430 00031100 0 55 0 0 0 0 0 0 0 0 1 3 7c 2 4 55 2 1 0 0 0
434 00062fc3 0 80000000 0 0 0 0 0 0 0 0 1 6 3 2 1f 80000000 5 1 0 0 0
438 01093806 4 ff00 0 0 0 0 0 0 1 8 1 9 2 2 4 ff00 7 1 0 0 0
// forwarding
43c 00222024 100 200 1 1 aaaa 1 1 bbbb 1 1 1 2 24 1 aaaa 200 4 1 0 0 0
440 00222024 100 200 1 5 aaaa 1 2 cccc 1 1 1 2 24 1 100 cccc 4 1 0 0 0
444 00222024 100 200 0 1 dddd 0 2 eeee 1 1 1 2 24 1 100 200 4 1 0 0 0
448 00421825 300 300 1 2 1234 1 2 5678 1 2 1 2 25 1 1234 1234 3 1 0 0 0
// branches
1000 10220004 5 5 0 0 0 0 0 0 1 1 1 2 51 6 5 5 0 0 0 1 1014
1000 1422fffe 5 5 1 2 6 0 0 0 1 1 1 2 52 6 5 6 0 0 0 1 ffc
1000 1422fffe 5 5 0 0 0 0 0 0 1 1 1 2 52 6 5 5 0 0 0 0 0
1000 1c600010 0 0 0 0 0 0 0 0 1 3 0 0 54 6 0 0 0 0 0 0 0
1000 1c600010 1 0 0 0 0 0 0 0 1 3 0 0 54 6 1 0 0 0 0 1 1044
1000 18600010 0 0 0 0 0 0 0 0 1 3 0 0 53 6 0 0 0 0 0 1 1044
1000 04810008 80000000 0 0 0 0 0 0 0 1 4 0 1 41 6 80000000 0 0 0 0 0 0
1000 04800008 80000000 0 0 0 0 0 0 0 1 4 0 0 40 6 80000000 0 0 0 0 1 1024
1000 04910008 7fffffff 0 0 0 0 0 0 0 1 4 0 11 4b 6 7fffffff 0 1f 1 1008 1 1024
1000 04900008 1 0 0 0 0 0 0 0 1 4 0 10 4a 6 1 0 1f 1 1008 0 0
// jumps and unknown encodings
3000fffc 08100040 0 0 0 0 0 0 0 0 0 0 0 10 4f 6 0 0 0 0 0 1 30400100
3000fffc 0c000003 0 0 0 0 0 0 0 0 0 0 0 0 50 6 0 0 1f 1 30010004 1 3000000c
500 01200008 111 0 1 9 402000 0 0 0 1 9 0 0 8 6 402000 0 0 0 0 1 402000
600 01202809 111 0 1 8 999 1 9 403000 1 9 0 0 9 6 403000 0 5 1 608 1 403000
700 ffffffff 0 0 0 0 0 0 0 0 0 1f 0 1f 0 0 0 0 0 0 0 0 0
704 00001810 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0

//--- all.f
design/id_pkg.sv
design/inst_decoder.sv
design/operand_forward.sv
design/branch_unit.sv
design/decode_stage.sv
verification/decode_stage_assertions.sv
verification/decode_stage_tb.sv

//--- Bender.yml
package:
  name: decode_stage

sources:
  - design/id_pkg.sv
  - design/inst_decoder.sv
  - design/operand_forward.sv
  - design/branch_unit.sv
  - design/decode_stage.sv
  - target: test
    files:
      - verification/decode_stage_assertions.sv
      - verification/decode_stage_tb.sv
